// File: common/flash_consts.svh
`ifndef FLASH_CONSTS_SVH
`define FLASH_CONSTS_SVH

// clk cycles per spi bit, power of two
`define FLASH_SCK_DIV 8

// clk cycles with ss_n high after the wake-up command
`define FLASH_WAKE_GAP 16

// field widths in bits
`define FLASH_CMD_BITS 8
`define FLASH_ADDR_BITS 24
`define FLASH_DATA_BITS 32

// width of the engine bit count, holds up to FLASH_DATA_BITS
`define FLASH_COUNT_BITS 6

`endif

// File: common/flash_pkg.sv
package flash_pkg;

   // request sequencer states
   typedef enum logic [3:0] {
      WAIT_ADDR = 4'd0,  // idle, address buffer free
      SEND_WAKE = 4'd1,  // release from deep power-down
      WAIT_WAKE = 4'd2,  // ss_n held high after wake-up
      SEND_CMD  = 4'd3,
      SEND_ADDR = 4'd4,
      READ_DATA = 4'd5,
      WAIT_ACK  = 4'd6   // word held for the host
   } seq_state_e;

   // flash opcodes, sent msb first
   typedef enum logic [7:0] {
      OP_WAKE = 8'hAB,
      OP_READ = 8'h03
   } spi_opcode_e;

   // spi output pins as one bundle
   typedef struct packed {
      logic sck;
      logic ss_n;   // active low
      logic mosi;
   } spi_pins_t;

endpackage

// File: flash_reader/spi_bit_engine.sv
`timescale 1ns/1ps
`include "flash_consts.svh"

module spi_bit_engine (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         start,
   input  logic [`FLASH_COUNT_BITS-1:0] bit_count,
   input  logic [`FLASH_DATA_BITS-1:0]  tx_word,    // left aligned
   input  logic                         miso,
   output logic                         sck,
   output logic                         mosi,
   output logic                         done,
   output logic [`FLASH_DATA_BITS-1:0]  rx_word     // right aligned, valid with done
);

   localparam int PHASE_W = $clog2(`FLASH_SCK_DIV);
   localparam int DATA_W  = `FLASH_DATA_BITS;
   localparam int COUNT_W = `FLASH_COUNT_BITS;

   localparam logic [PHASE_W-1:0] PH_SCK_RISE = PHASE_W'(`FLASH_SCK_DIV / 2 - 1); // last low phase
   localparam logic [PHASE_W-1:0] PH_SAMPLE   = PHASE_W'(`FLASH_SCK_DIV - 2);
   localparam logic [PHASE_W-1:0] PH_LAST     = PHASE_W'(`FLASH_SCK_DIV - 1);

   logic               busy;
   logic [PHASE_W-1:0] phase;
   logic [COUNT_W-1:0] bits_left;
   logic [DATA_W-1:0]  shreg;      // tx out of the top, rx into the bottom
   logic               miso_cap;
   logic               load;
   logic               last_bit;

   assign load     = start && !busy;
   assign last_bit = (bits_left == COUNT_W'(1));
   assign rx_word  = shreg;

   // control and pin registers
   always_ff @(posedge clk) begin
      if (reset) begin
         busy  <= 1'b0;
         phase <= '0;
         sck   <= 1'b0;
         mosi  <= 1'b0;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         if (load) begin
            busy  <= 1'b1;
            phase <= '0;
            mosi  <= tx_word[DATA_W-1];  // first bit valid from phase 0
         end else if (busy) begin
            phase <= phase + 1'b1;       // wraps back to phase 0
            if (phase == PH_SCK_RISE)
               sck <= 1'b1;
            if (phase == PH_LAST) begin
               sck <= 1'b0;
               if (last_bit) begin
                  busy <= 1'b0;
                  done <= 1'b1;
                  mosi <= 1'b0;          // idle low between fields
               end else begin
                  mosi <= shreg[DATA_W-2]; // next bit, seen at phase 0
               end
            end
         end
      end
   end

   // shift path
   always_ff @(posedge clk) begin
      if (load) begin
         shreg     <= tx_word;
         bits_left <= bit_count;
      end else if (busy) begin
         if (phase == PH_SAMPLE)
            miso_cap <= miso;            // mid high phase of sck
         if (phase == PH_LAST) begin
            shreg     <= {shreg[DATA_W-2:0], miso_cap};
            bits_left <= bits_left - 1'b1;
         end
      end
   end

endmodule

// File: flash_reader/flash_read_seq.sv
`timescale 1ns/1ps
`include "flash_consts.svh"

module flash_read_seq (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         addr_en,
   input  logic [`FLASH_ADDR_BITS-1:0]  addr_data,
   input  logic                         rd_ack,
   input  logic                         eng_done,
   input  logic [`FLASH_DATA_BITS-1:0]  eng_rx,
   output logic                         addr_buffer_free,
   output logic                         rd_data_available,
   output logic                         ss_n,
   output logic                         eng_start,
   output logic [`FLASH_COUNT_BITS-1:0] eng_bit_count,
   output logic [`FLASH_DATA_BITS-1:0]  eng_tx,
   output logic [`FLASH_DATA_BITS-1:0]  rd_data
);

   import flash_pkg::*;

   localparam int GAP_W   = $clog2(`FLASH_WAKE_GAP);
   localparam int COUNT_W = `FLASH_COUNT_BITS;
   localparam int CMD_PAD = `FLASH_DATA_BITS - `FLASH_CMD_BITS;
   localparam int ADR_PAD = `FLASH_DATA_BITS - `FLASH_ADDR_BITS;

   seq_state_e                  state;
   seq_state_e                  state_nx;
   logic                        start_nx;
   logic                        woken;     // wake-up already sent since reset
   logic [`FLASH_ADDR_BITS-1:0] addr_reg;
   logic [GAP_W-1:0]            gap_cnt;
   logic                        gap_done;
   logic                        accept;
   logic                        wake_done;
   logic                        data_done;
   logic                        release_word;

   assign accept       = (state == WAIT_ADDR) && addr_en && addr_buffer_free;
   assign gap_done     = (state == WAIT_WAKE) && (gap_cnt == GAP_W'(`FLASH_WAKE_GAP - 1));
   assign wake_done    = (state == SEND_WAKE) && eng_done;
   assign data_done    = (state == READ_DATA) && eng_done;
   assign release_word = (state == WAIT_ACK) && rd_ack;

   // next state, and a start pulse whenever a new field begins
   always_comb begin
      state_nx = state;
      start_nx = 1'b0;
      case (state)
         WAIT_ADDR: begin
            if (accept) begin
               state_nx = woken ? SEND_CMD : SEND_WAKE;
               start_nx = 1'b1;
            end
         end
         SEND_WAKE: if (eng_done) state_nx = WAIT_WAKE;
         WAIT_WAKE: begin
            if (gap_done) begin
               state_nx = SEND_CMD;
               start_nx = 1'b1;
            end
         end
         SEND_CMD: begin
            if (eng_done) begin
               state_nx = SEND_ADDR;  // address follows under the same ss_n
               start_nx = 1'b1;
            end
         end
         SEND_ADDR: begin
            if (eng_done) begin
               state_nx = READ_DATA;
               start_nx = 1'b1;
            end
         end
         READ_DATA: if (eng_done) state_nx = WAIT_ACK;
         WAIT_ACK:  if (rd_ack) state_nx = WAIT_ADDR;
         default:   state_nx = WAIT_ADDR;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state             <= WAIT_ADDR;
         woken             <= 1'b0;
         ss_n              <= 1'b1;
         addr_buffer_free  <= 1'b1;
         rd_data_available <= 1'b0;
         eng_start         <= 1'b0;
      end else begin
         state     <= state_nx;
         eng_start <= start_nx;
         if (start_nx)
            ss_n <= 1'b0;            // select before the first sck edge
         if (wake_done) begin
            ss_n  <= 1'b1;
            woken <= 1'b1;
         end
         if (data_done) begin
            ss_n              <= 1'b1;  // ends the read transaction
            rd_data_available <= 1'b1;
         end
         if (accept)
            addr_buffer_free <= 1'b0;
         if (release_word) begin
            rd_data_available <= 1'b0;
            addr_buffer_free  <= 1'b1;
         end
      end
   end

   // field contents and captured words
   always_ff @(posedge clk) begin
      if (accept)
         addr_reg <= addr_data;
      if (state == WAIT_WAKE)
         gap_cnt <= gap_cnt + 1'b1;
      else
         gap_cnt <= '0;
      if (start_nx) begin
         case (state_nx)
            SEND_WAKE: begin
               eng_tx        <= {OP_WAKE, {CMD_PAD{1'b0}}};
               eng_bit_count <= COUNT_W'(`FLASH_CMD_BITS);
            end
            SEND_CMD: begin
               eng_tx        <= {OP_READ, {CMD_PAD{1'b0}}};
               eng_bit_count <= COUNT_W'(`FLASH_CMD_BITS);
            end
            SEND_ADDR: begin
               eng_tx        <= {addr_reg, {ADR_PAD{1'b0}}};
               eng_bit_count <= COUNT_W'(`FLASH_ADDR_BITS);
            end
            default: begin
               eng_tx        <= '0;     // mosi stays low while reading
               eng_bit_count <= COUNT_W'(`FLASH_DATA_BITS);
            end
         endcase
      end
      if (data_done)
         rd_data <= eng_rx;
   end

endmodule

// File: logic/flash_reader_top.sv
`timescale 1ns/1ps
`include "flash_consts.svh"

module flash_reader_top (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        addr_en,
   input  logic [`FLASH_ADDR_BITS-1:0] addr_data,
   input  logic                        rd_ack,
   input  logic                        spi_miso,
   output logic                        addr_buffer_free,
   output logic                        rd_data_available,
   output logic [`FLASH_DATA_BITS-1:0] rd_data,
   output flash_pkg::spi_pins_t        spi_out
);

   logic                         eng_start;
   logic                         eng_done;
   logic [`FLASH_COUNT_BITS-1:0] eng_bit_count;
   logic [`FLASH_DATA_BITS-1:0]  eng_tx;
   logic [`FLASH_DATA_BITS-1:0]  eng_rx;
   logic                         sck;
   logic                         ss_n;
   logic                         mosi;

   flash_read_seq u_seq (
      .clk               (clk),
      .reset             (reset),
      .addr_en           (addr_en),
      .addr_data         (addr_data),
      .rd_ack            (rd_ack),
      .eng_done          (eng_done),
      .eng_rx            (eng_rx),
      .addr_buffer_free  (addr_buffer_free),
      .rd_data_available (rd_data_available),
      .ss_n              (ss_n),
      .eng_start         (eng_start),
      .eng_bit_count     (eng_bit_count),
      .eng_tx            (eng_tx),
      .rd_data           (rd_data)
   );

   spi_bit_engine u_engine (
      .clk       (clk),
      .reset     (reset),
      .start     (eng_start),
      .bit_count (eng_bit_count),
      .tx_word   (eng_tx),
      .miso      (spi_miso),
      .sck       (sck),
      .mosi      (mosi),
      .done      (eng_done),
      .rx_word   (eng_rx)
   );

   // pin bundle
   assign spi_out.sck  = sck;
   assign spi_out.ss_n = ss_n;
   assign spi_out.mosi = mosi;

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 5
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // reset covers the first RESET_CYCLES rising edges
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 reset = 1'b0;
   end

endmodule

// File: sim/spi_flash_model.sv
`timescale 1ns/1ps

module spi_flash_model (
   input  logic                 clk,
   input  flash_pkg::spi_pins_t pins,
   input  logic [31:0]          read_word,   // returned by the next read
   output logic                 miso,
   output logic [7:0]           txn_op,      // opcode of the last read frame
   output logic [23:0]          txn_addr,
   output int                   txn_edges,   // sck rising edges in the last frame
   output int                   wake_count,  // wake-up frames seen so far
   output int                   wake_gap,    // clk cycles ss_n stayed high after a wake-up
   output int                   sck_errs     // cycles with sck high and ss_n high
);

   import flash_pkg::*;

   logic        sck;
   logic        ss_n;
   logic        mosi;
   logic [31:0] cmd_sh;     // opcode then address, first bit ends on top
   int          bit_cnt;
   int          high_cnt;
   int          gap_seen;

   assign sck  = pins.sck;
   assign ss_n = pins.ss_n;
   assign mosi = pins.mosi;

   initial miso = 1'b0;  // low until the first read data goes out

   // a frame is one low period of ss_n and is decoded when ss_n rises
   always @(posedge sck or posedge ss_n) begin
      if (ss_n) begin
         if (bit_cnt != 0) begin
            txn_edges = bit_cnt;
            if (bit_cnt == 8 && cmd_sh[7:0] == OP_WAKE) begin
               wake_count++;
            end else begin
               txn_op   = cmd_sh[31:24];
               txn_addr = cmd_sh[23:0];
            end
         end
         bit_cnt = 0;
      end else begin
         if (bit_cnt < 32)
            cmd_sh = {cmd_sh[30:0], mosi};  // mosi is stable at the rising edge
         bit_cnt++;
      end
   end

   // data goes out msb first with a new bit after each falling edge from the last address bit on
   always @(negedge sck) begin
      if (!ss_n && bit_cnt >= 32 && bit_cnt < 64)
         miso = (cmd_sh[31:24] == OP_READ) ? read_word[5'(63 - bit_cnt)] : 1'b0;
   end

   always @(posedge clk) begin
      if (ss_n && sck)
         sck_errs++;
      if (ss_n) begin
         high_cnt++;
      end else begin
         if (wake_count != gap_seen) begin  // first low cycle after a wake-up gap
            wake_gap = high_cnt;
            gap_seen = wake_count;
         end
         high_cnt = 0;
      end
   end

endmodule

// File: sim/tb_flash_reader.sv
`timescale 1ns/1ps
`include "flash_consts.svh"

module tb_flash_reader;

   import flash_pkg::*;

   localparam int N_READS    = 8;
   localparam int GOLD_W     = $clog2(3 * N_READS);
   localparam int TIMEOUT    = 2000;  // clk cycles allowed for any one wait
   localparam int RESET_AT   = 5;     // this read is cut short by a reset first
   localparam int MID_CYCLES = 100;   // lands inside the address field
   localparam int READ_EDGES = `FLASH_CMD_BITS + `FLASH_ADDR_BITS + `FLASH_DATA_BITS;

   logic                        clk;
   logic                        rst_init;
   logic                        mid_reset;
   logic                        reset;
   logic                        addr_en;
   logic [`FLASH_ADDR_BITS-1:0] addr_data;
   logic                        rd_ack;
   logic                        spi_miso;
   logic                        addr_buffer_free;
   logic                        rd_data_available;
   logic [`FLASH_DATA_BITS-1:0] rd_data;
   spi_pins_t                   spi_out;
   logic [31:0]                 flash_word;
   logic [7:0]                  txn_op;
   logic [23:0]                 txn_addr;
   int                          txn_edges;
   int                          wake_count;
   int                          wake_gap;
   int                          sck_errs;

   logic [31:0] golden [0:3*N_READS-1];  // address, data, ack delay for each read
   int          errors;
   int          timeouts;
   int          exp_wakes;
   logic        first_read;                // next read is the first since reset

   assign reset = rst_init | mid_reset;

   tb_clock_gen u_clk (.clk(clk), .reset(rst_init));

   flash_reader_top u_dut (
      .clk               (clk),
      .reset             (reset),
      .addr_en           (addr_en),
      .addr_data         (addr_data),
      .rd_ack            (rd_ack),
      .spi_miso          (spi_miso),
      .addr_buffer_free  (addr_buffer_free),
      .rd_data_available (rd_data_available),
      .rd_data           (rd_data),
      .spi_out           (spi_out)
   );

   spi_flash_model u_flash (
      .clk        (clk),
      .pins       (spi_out),
      .read_word  (flash_word),
      .miso       (spi_miso),
      .txn_op     (txn_op),
      .txn_addr   (txn_addr),
      .txn_edges  (txn_edges),
      .wake_count (wake_count),
      .wake_gap   (wake_gap),
      .sck_errs   (sck_errs)
   );

   function automatic logic [31:0] golden_at(input int idx, input int col);
      return golden[GOLD_W'(3 * idx + col)];
   endfunction

   task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic note_timeout(input string what);
      timeouts++;
      $display("timeout at %0t: %s", $time, what);
   endtask

   task automatic check_reset_values();
      compare_value(32'(spi_out.ss_n), 32'd1, "ss_n after reset");
      compare_value(32'(spi_out.sck), 32'd0, "sck after reset");
      compare_value(32'(spi_out.mosi), 32'd0, "mosi after reset");
      compare_value(32'(rd_data_available), 32'd0, "rd_data_available after reset");
      compare_value(32'(addr_buffer_free), 32'd1, "addr_buffer_free after reset");
   endtask

   task automatic wait_for_reset_release();
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (reset && n < TIMEOUT);
      if (reset)
         note_timeout("reset was never released");
      #1;
   endtask

   task automatic send_request(input logic [23:0] addr);
      compare_value(32'(addr_buffer_free), 32'd1, "addr_buffer_free before request");
      addr_en   = 1'b1;
      addr_data = addr;
      @(posedge clk);
      #1;
      addr_en = 1'b0;
      compare_value(32'(addr_buffer_free), 32'd0, "addr_buffer_free after request");
   endtask

   // request, wait for the word, hold it for the golden delay, then acknowledge
   task automatic run_read(input int idx);
      logic [31:0] addr;
      logic [31:0] word;
      int          hold;
      int          n;
      addr       = golden_at(idx, 0);
      word       = golden_at(idx, 1);
      hold       = golden_at(idx, 2);
      flash_word = word;
      send_request(addr[23:0]);
      if (first_read)
         exp_wakes++;
      n = 0;
      while (!rd_data_available && n < TIMEOUT) begin
         compare_value(32'(addr_buffer_free), 32'd0, "addr_buffer_free during read");
         @(posedge clk);
         #1;
         n++;
      end
      if (!rd_data_available) begin
         note_timeout("rd_data_available never rose");
         return;
      end
      compare_value(rd_data, word, "rd_data");
      compare_value(32'(spi_out.ss_n), 32'd1, "ss_n as data becomes available");
      compare_value(32'(txn_op), 32'(OP_READ), "read opcode");
      compare_value(32'(txn_addr), addr, "read address");
      compare_value(txn_edges, READ_EDGES, "sck rising edges in read");
      compare_value(wake_count, exp_wakes, "wake-up commands sent");
      if (first_read)
         compare_value(32'(wake_gap >= `FLASH_WAKE_GAP), 32'd1, "ss_n high gap after wake-up");
      first_read = 1'b0;
      repeat (hold) begin
         @(posedge clk);
         #1;
         compare_value(32'(rd_data_available), 32'd1, "rd_data_available before rd_ack");
         compare_value(rd_data, word, "rd_data before rd_ack");
         compare_value(32'(spi_out.ss_n), 32'd1, "ss_n before rd_ack");
         compare_value(32'(addr_buffer_free), 32'd0, "addr_buffer_free before rd_ack");
      end
      rd_ack = 1'b1;
      @(posedge clk);
      #1;
      rd_ack = 1'b0;
      compare_value(32'(rd_data_available), 32'd0, "rd_data_available after rd_ack");
      compare_value(32'(addr_buffer_free), 32'd1, "addr_buffer_free after rd_ack");
   endtask

   task automatic interrupt_with_reset(input int idx);
      int n;
      flash_word = golden_at(idx, 1);
      send_request(24'(golden_at(idx, 0)));
      n = 0;
      while (spi_out.ss_n && n < TIMEOUT) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (spi_out.ss_n) begin
         note_timeout("ss_n never fell for the interrupted read");
         return;
      end
      repeat (MID_CYCLES) @(posedge clk);
      #1;
      mid_reset = 1'b1;
      @(posedge clk);
      #1;
      mid_reset = 1'b0;
      check_reset_values();
      first_read = 1'b1;  // wake-up is due again
   endtask

   initial begin
      int gap;
      void'($urandom(32'h4675));
      addr_en    = 1'b0;
      addr_data  = '0;
      rd_ack     = 1'b0;
      mid_reset  = 1'b0;
      flash_word = '0;
      errors     = 0;
      timeouts   = 0;
      exp_wakes  = 0;
      first_read = 1'b1;
      $readmemh("sim/flash_golden.txt", golden);
      wait_for_reset_release();
      check_reset_values();
      for (int i = 0; i < N_READS && timeouts == 0; i++) begin
         if (i == RESET_AT)
            interrupt_with_reset(i);
         if (timeouts == 0)
            run_read(i);
         gap = $urandom_range(3, 0);  // idle cycles before the next request
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
      end
      compare_value(sck_errs, 0, "cycles with sck high while ss_n high");
      $display("reads %0d, errors %0d, timeouts %0d", N_READS, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// File: sim/flash_golden.txt
// columns: address (24 bit hex), data word (32 bit hex), ack delay in clk cycles (hex)
// one read per line, requested in this order
000000 A5C3F00F 0
000004 DEADBEEF 3
01F3A8 12345678 1
7FFFFC 80000001 7
123456 CAFEF00D 2
FFFFFF 0F1E2D3C 5
00ABCD 55AA33CC 0
A00A00 FFFFFFFF 4

// File: build.f
+incdir+common
common/flash_pkg.sv
flash_reader/spi_bit_engine.sv
flash_reader/flash_read_seq.sv
logic/flash_reader_top.sv
sim/tb_clock_gen.sv
sim/spi_flash_model.sv
sim/tb_flash_reader.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f build.f --top-module tb_flash_reader \
   && ./obj_dir/Vtb_flash_reader > sim.log 2>&1 \
   || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
